//--- hw/bt_link_pkg.sv
// Bluetooth datastream link definitions
// Sizes, framed packet layout and the sender FSM states

`default_nettype none

package bt_link_pkg;

	// Channel and packet sizes
	localparam int NUM_CHANNELS = 4;
	localparam int CHAN_W = 2;
	localparam int PAYLOAD_BYTES = 6;
	localparam int PACKET_BYTES = PAYLOAD_BYTES + 2;
	localparam int BYTE_IDX_W = 3;

	// Buffering and line timing
	localparam int FIFO_DEPTH = 4;
	localparam int PACKET_GAP = 200;
	localparam int TIMER_W = 10;

	typedef logic [CHAN_W-1:0] chan_t;

	// First byte on the line is bits 47..40
	typedef logic [8*PAYLOAD_BYTES-1:0] payload_t;

	typedef struct packed {
		logic valid;
		chan_t chan;
		payload_t payload;
	} sample_t;

	// Channel number framed on both sides of the payload
	typedef struct packed {
		logic [7:0] head;
		payload_t payload;
		logic [7:0] tail;
	} packet_t;

	typedef enum logic [2:0] {S_IDLE, S_CLEARANCE, S_LOAD, S_SEND, S_GAP} sender_state_t;

endpackage

`default_nettype wire

//--- hw/stream_fifo.sv
// Per-channel packet FIFO, first word fall through
// Pushes while full are dropped

`default_nettype none
`timescale 1ns/10ps

module stream_fifo (
	input wire logic clock,
	input wire logic reset,
	input wire logic push_i,
	input bt_link_pkg::packet_t packet_i,
	input wire logic pop_i,
	output bt_link_pkg::packet_t head_o,
	output logic empty_o,
	output logic full_o
);

	bt_link_pkg::packet_t mem [bt_link_pkg::FIFO_DEPTH];
	logic [$clog2(bt_link_pkg::FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(bt_link_pkg::FIFO_DEPTH):0] count;
	logic push_ok, pop_ok;

	assign empty_o = (count == '0);
	assign full_o = (int'(count) == bt_link_pkg::FIFO_DEPTH);
	assign push_ok = push_i && !full_o;
	assign pop_ok = pop_i && !empty_o;
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (push_ok)
			mem[wr_ptr] <= packet_i;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= (int'(wr_ptr) == bt_link_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (int'(rd_ptr) == bt_link_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sender only pops the channel the arbiter found non-empty
	a_no_pop_empty: assert property (@(posedge clock) disable iff (reset) pop_i |-> !empty_o);
	a_count_bound: assert property (@(posedge clock) disable iff (reset)
		int'(count) <= bt_link_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

//--- hw/stream_arbiter.sv
// Round-robin stream arbiter
// Picks the next non-empty channel after the last grant on each request

`default_nettype none
`timescale 1ns/10ps

module stream_arbiter (
	input wire logic clock,
	input wire logic reset,
	input wire logic request_i,
	input wire logic [bt_link_pkg::NUM_CHANNELS-1:0] empty_i,
	output bt_link_pkg::chan_t grant_o,
	output logic grant_valid_o
);

	bt_link_pkg::chan_t next_grant;
	logic found;
	int cand;
	logic [bt_link_pkg::NUM_CHANNELS-1:0] grant_onehot;

	// Search starts one past the last granted channel
	always_comb
	begin
		found = 1'b0;
		next_grant = grant_o;
		cand = 0;
		for (int i = 1; i <= bt_link_pkg::NUM_CHANNELS; i++)
		begin
			cand = (int'(grant_o) + i) % bt_link_pkg::NUM_CHANNELS;
			if (!found && !empty_i[cand])
			begin
				found = 1'b1;
				next_grant = bt_link_pkg::chan_t'(cand);
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			// Last channel, so the first search begins at channel 0
			grant_o <= bt_link_pkg::chan_t'(bt_link_pkg::NUM_CHANNELS - 1);
			grant_valid_o <= 1'b0;
		end
		else
		begin
			grant_valid_o <= request_i && found;
			if (request_i && found)
				grant_o <= next_grant;
		end
	end

	assign grant_onehot = {{(bt_link_pkg::NUM_CHANNELS - 1){1'b0}}, 1'b1} << grant_o;

	a_grant_nonempty: assert property (@(posedge clock) disable iff (reset)
		grant_valid_o |-> $past(request_i) && ((($past(empty_i)) & grant_onehot) == '0));

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
// UART transmitter, 8N1 with a run-time bit period
// One done pulse at the end of each stop bit

`default_nettype none
`timescale 1ns/10ps

module uart_tx (
	input wire logic clock,
	input wire logic reset,
	input wire logic start_i,
	input wire logic [7:0] data_i,
	input wire logic [bt_link_pkg::TIMER_W-1:0] cycles_per_bit_i,
	output logic txd_o,
	output logic done_o
);

	logic busy;
	logic [bt_link_pkg::TIMER_W-1:0] bit_timer;
	logic [3:0] bit_cnt;
	logic [8:0] shift;
	logic bit_end;

	assign bit_end = (bit_timer == cycles_per_bit_i - 1'b1);

	// Data LSB first with the stop bit behind it
	always_ff @(posedge clock)
	begin
		if (start_i && !busy)
			shift <= {1'b1, data_i};
		else if (busy && bit_end)
			shift <= {1'b1, shift[8:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_timer <= '0;
			bit_cnt <= '0;
			txd_o <= 1'b1;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (!busy)
			begin
				if (start_i)
				begin
					// Start bit goes out right away
					busy <= 1'b1;
					txd_o <= 1'b0;
					bit_timer <= '0;
					bit_cnt <= '0;
				end
			end
			else if (!bit_end)
				bit_timer <= bit_timer + 1'b1;
			else
			begin
				bit_timer <= '0;
				if (bit_cnt == 4'd9)
				begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end
				else
				begin
					txd_o <= shift[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	a_no_start_busy: assert property (@(posedge clock) disable iff (reset) start_i |-> !busy);

endmodule

`default_nettype wire

//--- hw/packet_sender.sv
// Packet sender FSM
// Pulls one framed packet at a time and feeds it to the UART byte by byte,
// with a byte gap inside a packet and a longer gap after it

`default_nettype none
`timescale 1ns/10ps

module packet_sender (
	input wire logic clock,
	input wire logic reset,
	input wire logic enable_i,
	input wire logic any_data_i,
	input wire logic grant_valid_i,
	input bt_link_pkg::packet_t packet_i,
	input wire logic [bt_link_pkg::TIMER_W-1:0] byte_gap_i,
	input wire logic tx_done_i,
	output logic request_o,
	output logic pop_o,
	output logic tx_start_o,
	output logic [7:0] tx_byte_o,
	output logic busy_o
);

	bt_link_pkg::sender_state_t state, state_next;
	bt_link_pkg::packet_t packet_q;
	logic [bt_link_pkg::BYTE_IDX_W-1:0] byte_idx;
	logic [bt_link_pkg::TIMER_W-1:0] gap_cnt;
	logic byte_started;
	logic last_byte;
	logic gap_done;
	logic want_packet;
	int gap_limit;

	assign last_byte = (int'(byte_idx) == bt_link_pkg::PACKET_BYTES - 1);
	assign gap_limit = last_byte ? bt_link_pkg::PACKET_GAP : int'(byte_gap_i);
	assign gap_done = (int'(gap_cnt) >= gap_limit);
	assign want_packet = enable_i && any_data_i;

	assign request_o = (state == bt_link_pkg::S_CLEARANCE);
	assign pop_o = (state == bt_link_pkg::S_LOAD) && grant_valid_i;
	assign tx_start_o = (state == bt_link_pkg::S_SEND) && !byte_started;
	assign busy_o = (state != bt_link_pkg::S_IDLE);

	// Head byte sits in the top bits
	assign tx_byte_o = packet_q[8 * (bt_link_pkg::PACKET_BYTES - 1 - int'(byte_idx)) +: 8];

	always_comb
	begin
		state_next = state;
		case (state)
			bt_link_pkg::S_IDLE:
				if (want_packet)
					state_next = bt_link_pkg::S_CLEARANCE;
			bt_link_pkg::S_CLEARANCE:
				state_next = bt_link_pkg::S_LOAD;
			bt_link_pkg::S_LOAD:
				state_next = grant_valid_i ? bt_link_pkg::S_SEND : bt_link_pkg::S_IDLE;
			bt_link_pkg::S_SEND:
				if (tx_done_i)
					state_next = bt_link_pkg::S_GAP;
			bt_link_pkg::S_GAP:
			begin
				if (gap_done)
				begin
					if (!last_byte)
						state_next = bt_link_pkg::S_SEND;
					else if (want_packet)
						state_next = bt_link_pkg::S_CLEARANCE;
					else
						state_next = bt_link_pkg::S_IDLE;
				end
			end
			default:
				state_next = bt_link_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (pop_o)
			packet_q <= packet_i;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= bt_link_pkg::S_IDLE;
			byte_idx <= '0;
			gap_cnt <= '0;
			byte_started <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (pop_o)
				byte_idx <= '0;
			else if (state == bt_link_pkg::S_GAP && gap_done && !last_byte)
				byte_idx <= byte_idx + 1'b1;
			// Gap counter runs only while resting between bytes
			if (state == bt_link_pkg::S_GAP)
				gap_cnt <= gap_cnt + 1'b1;
			else
				gap_cnt <= '0;
			if (tx_start_o)
				byte_started <= 1'b1;
			else if (tx_done_i)
				byte_started <= 1'b0;
		end
	end

	a_start_in_send: assert property (@(posedge clock) disable iff (reset)
		tx_start_o |-> (state == bt_link_pkg::S_SEND) && !$past(tx_start_o));

endmodule

`default_nettype wire

//--- hw/bt_link_top.sv
// Bluetooth datastream link top level
// Frames sensor samples into per-channel FIFOs and streams them out over UART

`default_nettype none
`timescale 1ns/10ps

module bt_link_top (
	input wire logic clock,
	input wire logic reset,
	input bt_link_pkg::sample_t sample_i,
	input wire logic enable_i,
	input wire logic [bt_link_pkg::TIMER_W-1:0] cycles_per_bit_i,
	input wire logic [bt_link_pkg::TIMER_W-1:0] byte_gap_i,
	output logic txd_o,
	output logic busy_o
);

	bt_link_pkg::packet_t framed;
	bt_link_pkg::packet_t heads [bt_link_pkg::NUM_CHANNELS];
	bt_link_pkg::packet_t granted;
	bt_link_pkg::chan_t grant;
	logic [bt_link_pkg::NUM_CHANNELS-1:0] push, pop, empty;
	logic grant_valid, request, sender_pop;
	logic tx_start, tx_done;
	logic [7:0] tx_byte;

	// Channel number on both ends of the payload
	assign framed.head = {{(8 - bt_link_pkg::CHAN_W){1'b0}}, sample_i.chan};
	assign framed.payload = sample_i.payload;
	assign framed.tail = {{(8 - bt_link_pkg::CHAN_W){1'b0}}, sample_i.chan};

	for (genvar ch = 0; ch < bt_link_pkg::NUM_CHANNELS; ch++)
	begin : g_chan
		assign push[ch] = sample_i.valid && (int'(sample_i.chan) == ch);
		assign pop[ch] = sender_pop && (int'(grant) == ch);

		stream_fifo u_fifo (
			.clock(clock), .reset(reset),
			.push_i(push[ch]), .packet_i(framed), .pop_i(pop[ch]),
			.head_o(heads[ch]), .empty_o(empty[ch]), .full_o()
		);
	end

	assign granted = heads[grant];

	stream_arbiter u_arbiter (
		.clock(clock), .reset(reset), .request_i(request), .empty_i(empty),
		.grant_o(grant), .grant_valid_o(grant_valid)
	);

	packet_sender u_sender (
		.clock(clock), .reset(reset), .enable_i(enable_i), .any_data_i(~&empty),
		.grant_valid_i(grant_valid), .packet_i(granted), .byte_gap_i(byte_gap_i),
		.tx_done_i(tx_done), .request_o(request), .pop_o(sender_pop),
		.tx_start_o(tx_start), .tx_byte_o(tx_byte), .busy_o(busy_o)
	);

	uart_tx u_uart (
		.clock(clock), .reset(reset), .start_i(tx_start), .data_i(tx_byte),
		.cycles_per_bit_i(cycles_per_bit_i), .txd_o(txd_o), .done_o(tx_done)
	);

endmodule

`default_nettype wire

//--- verification/bt_link_tb.sv
// Testbench for the Bluetooth datastream link
// Replays the pattern file, decodes the serial line and checks bytes and gaps

`default_nettype none
`timescale 1ns/10ps

module bt_link_tb;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_RECORDS = 64;
	localparam logic [bt_link_pkg::TIMER_W-1:0] CYCLES_PER_BIT = 4;
	localparam logic [bt_link_pkg::TIMER_W-1:0] BYTE_GAP = 6;
	// Gap given to the very first frame on the line
	localparam int FIRST_GAP = 32'h7fffffff;

	// Record opcodes in bits 79..72
	localparam logic [7:0] OP_END = 8'h00;
	localparam logic [7:0] OP_WRITE = 8'h01;
	localparam logic [7:0] OP_ENABLE = 8'h02;
	localparam logic [7:0] OP_WAIT = 8'h03;
	localparam logic [7:0] OP_EXPECT = 8'h04;
	localparam logic [7:0] OP_IDLE = 8'h05;
	localparam logic [7:0] OP_TEST_END = 8'h06;

	logic clock;
	logic reset;
	bt_link_pkg::sample_t sample;
	logic enable;
	logic [bt_link_pkg::TIMER_W-1:0] cycles_per_bit;
	logic [bt_link_pkg::TIMER_W-1:0] byte_gap;
	logic txd;
	logic busy;

	logic [79:0] records [MAX_RECORDS];
	logic [7:0] rx_bytes [$];
	int rx_gaps [$];
	int cycle_count = 0;
	int cycle_limit = 0;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_done = 0;

	bt_link_top u_dut (
		.clock(clock), .reset(reset), .sample_i(sample), .enable_i(enable),
		.cycles_per_bit_i(cycles_per_bit), .byte_gap_i(byte_gap),
		.txd_o(txd), .busy_o(busy)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, expected traffic never arrived", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic string test_name(input int number);
		case (number)
			1: return "idle after reset";
			2: return "round robin from reset";
			3: return "framing on channel 2";
			4: return "round robin continued";
			5: return "overflow of one FIFO";
			6: return "enable low mid packet";
			default: return "unnamed";
		endcase
	endfunction

	// Line time of the whole stimulus for the run limit
	function automatic int stimulus_cycles();
		int sum;
		logic [7:0] op;
		sum = 0;
		for (int i = 0; i < MAX_RECORDS; i++)
		begin
			op = records[i][79:72];
			if (op == OP_WAIT || op == OP_IDLE)
				sum += int'(records[i][31:0]);
			else if (op == OP_EXPECT)
				sum += bt_link_pkg::PACKET_BYTES * 10 * int'(CYCLES_PER_BIT)
					+ (bt_link_pkg::PACKET_BYTES - 1) * int'(BYTE_GAP)
					+ bt_link_pkg::PACKET_GAP;
		end
		return sum;
	endfunction

	task automatic check_equal(input string name, input logic [63:0] expected,
		input logic [63:0] got);
		test_checks++;
		assert (got === expected)
		else
		begin
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, got);
			test_errors++;
		end
	endtask

	task automatic check_at_least(input string name, input int minimum, input int got);
		test_checks++;
		assert (got >= minimum)
		else
		begin
			$display("FAIL t=%0t %s expected >= %0d got %0d", $time, name, minimum, got);
			test_errors++;
		end
	endtask

	// Entered half a cycle into the start bit and left in the last stop bit cycle
	task automatic receive_frame(output logic [7:0] data, output logic stop_ok);
		logic [9:0] bits;
		repeat (CYCLES_PER_BIT / 2)
			@(negedge clock);
		bits[0] = txd;
		for (int i = 1; i < 10; i++)
		begin
			repeat (CYCLES_PER_BIT)
				@(negedge clock);
			bits[i] = txd;
		end
		repeat (CYCLES_PER_BIT - CYCLES_PER_BIT / 2 - 1)
			@(negedge clock);
		data = bits[8:1];
		stop_ok = (bits[0] == 1'b0) && (bits[9] == 1'b1);
	endtask

	// Serial line monitor that counts idle cycles before each frame
	initial
	begin : line_monitor
		int idle;
		logic seen_frame;
		logic [7:0] data;
		logic stop_ok;
		idle = 0;
		seen_frame = 1'b0;
		@(negedge reset);
		forever
		begin
			@(negedge clock);
			if (txd === 1'b1)
				idle++;
			else
			begin
				receive_frame(data, stop_ok);
				assert (stop_ok)
				else
				begin
					$display("Framing error at %0t, start or stop bit has the wrong level", $time);
					test_errors++;
				end
				rx_bytes.push_back(data);
				rx_gaps.push_back(seen_frame ? idle : FIRST_GAP);
				seen_frame = 1'b1;
				idle = 0;
			end
		end
	end

	task automatic write_sample(input bt_link_pkg::chan_t chan,
		input bt_link_pkg::payload_t payload);
		sample.valid = 1'b1;
		sample.chan = chan;
		sample.payload = payload;
		@(negedge clock);
		sample = '0;
	endtask

	// Bytes come head first and the first one follows the previous packet's gap
	task automatic expect_packet(input logic [63:0] bytes);
		logic [7:0] got;
		int gap;
		int min_gap;
		for (int i = 0; i < bt_link_pkg::PACKET_BYTES; i++)
		begin
			while (rx_bytes.size() == 0)
				@(negedge clock);
			got = rx_bytes.pop_front();
			gap = rx_gaps.pop_front();
			min_gap = (i == 0) ? bt_link_pkg::PACKET_GAP : int'(BYTE_GAP);
			check_equal("txd_o byte", bytes[63 - 8 * i -: 8], got);
			check_at_least("txd_o idle cycles", min_gap, gap);
			// Sender stays out of idle until the packet gap has run out
			check_equal("busy_o", 64'd1, busy);
		end
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clock);
			check_equal("txd_o", 64'd1, txd);
			check_equal("busy_o", 64'd0, busy);
		end
		test_checks++;
		assert (rx_bytes.size() == 0)
		else
		begin
			$display("Unexpected bytes on the line at %0t, %0d not claimed by any packet",
				$time, rx_bytes.size());
			test_errors++;
			rx_bytes.delete();
			rx_gaps.delete();
		end
	endtask

	initial
	begin : main
		logic [79:0] rec;
		reset = 1'b1;
		enable = 1'b0;
		sample = '0;
		cycles_per_bit = CYCLES_PER_BIT;
		byte_gap = BYTE_GAP;
		for (int i = 0; i < MAX_RECORDS; i++)
			records[i] = '0;
		$readmemh("verification/bt_link_patterns.txt", records);
		cycle_limit = RESET_CYCLES + 4 * stimulus_cycles();
		repeat (RESET_CYCLES)
			@(negedge clock);
		reset = 1'b0;
		for (int idx = 0; idx < MAX_RECORDS; idx++)
		begin
			rec = records[idx];
			if (rec[79:72] == OP_END)
				break;
			case (rec[79:72])
				OP_WRITE: write_sample(bt_link_pkg::chan_t'(rec[65:64]), rec[47:0]);
				OP_ENABLE: enable = rec[64];
				OP_WAIT: repeat (int'(rec[31:0])) @(negedge clock);
				OP_EXPECT: expect_packet(rec[63:0]);
				OP_IDLE: check_idle(int'(rec[31:0]));
				OP_TEST_END:
				begin
					$display("Test %0d %s: %0d checks, %0d errors", int'(rec[71:64]),
						test_name(int'(rec[71:64])), test_checks, test_errors);
					total_checks += test_checks;
					total_errors += test_errors;
					test_checks = 0;
					test_errors = 0;
					tests_done++;
				end
				default:
				begin
					$display("Unknown record %0h at line %0d of the pattern file", rec, idx);
					test_errors++;
				end
			endcase
		end
		total_checks += test_checks;
		total_errors += test_errors;
		$display("Tests %0d, checks %0d, errors %0d", tests_done, total_checks, total_errors);
		if (total_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
hw/bt_link_pkg.sv
hw/stream_fifo.sv
hw/stream_arbiter.sv
hw/uart_tx.sv
hw/packet_sender.sv
hw/bt_link_top.sv
verification/bt_link_tb.sv

//--- Makefile
# Verilator build and run for the Bluetooth datastream link

VERILATOR ?= verilator
TOP ?= bt_link_tb
OBJ_DIR ?= obj_dir
FILELIST ?= tb.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- verification/bt_link_patterns.txt
// Word: op[79:72] arg[71:64] data[63:0], arg is channel or enable level
// Ops: 01 write, 02 enable, 03 wait cycles, 04 expect 8 bytes, 05 idle check cycles, 06 end test
// Idle after reset, with enable low and then high
05000000000000000020
02010000000000000000
05000000000000000020
02000000000000000000
06010000000000000000
// Round robin from reset, search starts at channel 0
01030000a1a2a3a4a5a6
01010000b1b2b3b4b5b6
01000000c1c2c3c4c5c6
02010000000000000000
040000c1c2c3c4c5c600
040101b1b2b3b4b5b601
040303a1a2a3a4a5a603
06020000000000000000
// Framing on channel 2
01020000123456789abc
040202123456789abc02
02000000000000000000
06030000000000000000
// Round robin continues after channel 2
01010000d1d2d3d4d5d6
01030000e1e2e3e4e5e6
01000000f1f2f3f4f5f6
02010000000000000000
040303e1e2e3e4e5e603
040000f1f2f3f4f5f600
040101d1d2d3d4d5d601
02000000000000000000
06040000000000000000
// Five samples into one FIFO, the fifth is dropped
010200005a0000000001
010200005a0000000002
010200005a0000000003
010200005a0000000004
010200005a0000000005
02010000000000000000
0402025a000000000102
0402025a000000000202
0402025a000000000302
0402025a000000000402
03000000000000000100
05000000000000000040
06050000000000000000
// Enable drops while channel 0 is on the line
02000000000000000000
01010000717273747576
01000000818283848586
02010000000000000000
03000000000000000014
02000000000000000000
04000081828384858600
03000000000000000100
05000000000000000040
02010000000000000000
04010171727374757601
06060000000000000000
00000000000000000000
